// ==== axi2apb_shim.f ====
verilog/axi2apb_pkg.sv
verilog/axi2apb_burst_counter.sv
verilog/apb_master.sv
verilog/axi2apb_ctrl_fsm.sv
verilog/axi2apb_shim.sv
dv/axi2apb_shim_checker.sv
dv/axi2apb_shim_tb.sv

// ==== Bender.yml ====
package:
  name: axi2apb_shim

sources:
  - verilog/axi2apb_pkg.sv
  - verilog/axi2apb_burst_counter.sv
  - verilog/apb_master.sv
  - verilog/axi2apb_ctrl_fsm.sv
  - verilog/axi2apb_shim.sv
  - target: test
    files:
      - dv/axi2apb_shim_checker.sv
      - dv/axi2apb_shim_tb.sv

// ==== dv/axi2apb_shim_tb.sv ====
`timescale 1ns/1ps

module axi2apb_shim_tb
    import axi2apb_pkg::*;
();

    localparam int NUM_TXN    = 40;
    localparam int TIMEOUT_NS = NUM_TXN * 8 * 20 * 4;

    logic        aclk;
    logic        aresetn;
    axi_ax_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    axi_b_t      b;
    logic        b_valid;
    logic        b_ready;
    axi_ax_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic [31:0] lfsr = 32'hd010f53c;
    logic [31:0] slave_mem [0:1023];
    logic [31:0] model_mem [0:1023];
    apb_cmd_t    exp_apb [$];
    axi_b_t      exp_b [$];
    axi_r_t      exp_r [$];
    int          waits = 0;

    axi2apb_shim i_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_aw       (aw),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_w        (w),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .o_b        (b),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready),
        .i_ar       (ar),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r        (r),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .o_apb      (apb_req),
        .i_apb      (apb_rsp)
    );

    always #2 aclk = ~aclk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_err_page(input logic [31:0] addr);
        return addr[11:8] == 4'hf;
    endfunction

    function automatic logic [31:0] beat_addr(input axi_ax_t ax, input int k);
        return (ax.burst == burst_fixed) ? ax.addr : ax.addr + 32'(4 * k);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] v;
        v = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                v[8*i +: 8] = data[8*i +: 8];
            end
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    // APB slave drawing its wait states when setup is seen
    always @(posedge aclk) begin
        apb_cmd_t e;
        if (apb_req.psel && !apb_req.penable) begin
            waits = take_bits(2);
        end else if (apb_req.penable && apb_rsp.pready) begin
            assert (exp_apb.size() != 0) else abort_run("APB transfer with none expected");
            e = exp_apb.pop_front();
            check_eq("o_apb.paddr", e.addr, apb_req.paddr);
            check_eq("o_apb.pwrite", e.op == op_write, apb_req.pwrite);
            check_eq("o_apb.pwdata", e.wdata, apb_req.pwdata);
            check_eq("o_apb.pstrb", e.strb, apb_req.pstrb);
            check_eq("o_apb.pprot", e.prot, apb_req.pprot);
            if (apb_req.pwrite && !is_err_page(apb_req.paddr)) begin
                slave_mem[apb_req.paddr[11:2]] = merge_bytes(slave_mem[apb_req.paddr[11:2]],
                                                             apb_req.pwdata, apb_req.pstrb);
            end
        end else if (apb_req.penable) begin
            waits = waits - 1;
        end
    end

    always @(negedge aclk) begin
        apb_rsp.pready  = apb_req.penable && (waits == 0);
        apb_rsp.pslverr = apb_req.psel && is_err_page(apb_req.paddr);
        apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite && !is_err_page(apb_req.paddr)) ?
                          slave_mem[apb_req.paddr[11:2]] : '0;
    end

    // Response scoreboard
    always @(posedge aclk) begin
        if (b_valid && b_ready) begin
            assert (exp_b.size() != 0) else abort_run("B response with none expected");
            check_eq("o_b.id", exp_b[0].id, b.id);
            check_eq("o_b.resp", exp_b[0].resp, b.resp);
            void'(exp_b.pop_front());
        end
        if (r_valid && r_ready) begin
            assert (exp_r.size() != 0) else abort_run("R beat with none expected");
            check_eq("o_r.id", exp_r[0].id, r.id);
            check_eq("o_r.data", exp_r[0].data, r.data);
            check_eq("o_r.resp", exp_r[0].resp, r.resp);
            check_eq("o_r.last", exp_r[0].last, r.last);
            void'(exp_r.pop_front());
        end
    end

    task automatic send_addr(input logic write, input axi_ax_t ax);
        @(negedge aclk);
        if (write) begin
            aw       = ax;
            aw_valid = 1'b1;
        end else begin
            ar       = ax;
            ar_valid = 1'b1;
        end
        do @(posedge aclk); while (!(write ? aw_ready : ar_ready));
        @(negedge aclk);
        aw_valid = 1'b0;
        ar_valid = 1'b0;
    endtask

    // Random BREADY and RREADY stalls until one response handshake
    task automatic wait_response();
        logic ready;
        do begin
            @(negedge aclk);
            ready   = (take_bits(2) != 0);
            b_ready = ready;
            r_ready = ready;
            @(posedge aclk);
        end while (!((b_valid || r_valid) && ready));
    endtask

    task automatic run_write(input axi_ax_t ax);
        logic        err;
        logic [31:0] addr;
        err = 1'b0;
        send_addr(1'b1, ax);
        for (int k = 0; k <= int'(ax.len); k++) begin
            @(negedge aclk);
            w.data  = take_bits(32);
            w.strb  = 4'(take_bits(4));
            w.last  = (k == int'(ax.len));
            w_valid = 1'b1;
            addr    = beat_addr(ax, k);
            exp_apb.push_back(apb_cmd_t'{op_write, addr, w.data, w.strb, ax.prot});
            if (is_err_page(addr)) begin
                err = 1'b1;
            end else begin
                model_mem[addr[11:2]] = merge_bytes(model_mem[addr[11:2]], w.data, w.strb);
            end
            do @(posedge aclk); while (!w_ready);
        end
        exp_b.push_back(axi_b_t'{ax.id, err ? resp_slverr : resp_okay});
        @(negedge aclk);
        w_valid = 1'b0;
        wait_response();
    endtask

    task automatic run_read(input axi_ax_t ax);
        logic [31:0] addr;
        logic        err;
        for (int k = 0; k <= int'(ax.len); k++) begin
            addr = beat_addr(ax, k);
            err  = is_err_page(addr);
            exp_apb.push_back(apb_cmd_t'{op_read, addr, 32'h0, 4'h0, ax.prot});
            exp_r.push_back(axi_r_t'{ax.id, err ? 32'h0 : model_mem[addr[11:2]],
                                     err ? resp_slverr : resp_okay, k == int'(ax.len)});
        end
        send_addr(1'b0, ax);
        for (int k = 0; k <= int'(ax.len); k++) begin
            wait_response();
        end
    endtask

    initial begin
        #(TIMEOUT_NS * 1ns);
        abort_run("timeout before all transactions completed");
    end

    initial begin
        axi_ax_t    ax;
        logic       write;
        logic [3:0] page;
        aclk     = 1'b0;
        aresetn  = 1'b0;
        aw       = '0;
        ar       = '0;
        w        = '0;
        aw_valid = 1'b0;
        ar_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        r_ready  = 1'b0;
        apb_rsp  = '0;
        ax       = '0;
        for (int a = 0; a < 1024; a++) begin
            slave_mem[a] = '0;
            model_mem[a] = '0;
        end
        repeat (2) @(negedge aclk);
        aresetn = 1'b1;
        for (int t = 0; t < NUM_TXN; t++) begin
            // Odd slots read back the previous burst
            if (t % 2 == 0) begin
                write = 1'(take_bits(1));
                page  = 4'(take_bits(2));
                if (take_bits(2) == 0) begin
                    page = 4'hf;
                end
                ax.addr  = {20'h0, page, 2'b00, 4'(take_bits(4)), 2'b00};
                // Some bursts straddle an edge of the error page
                if (page == 4'hf && take_bits(1)) begin
                    ax.addr = take_bits(1) ? ax.addr + 32'he0 : ax.addr - 32'h20;
                end
                ax.len   = 8'(take_bits(3));
                ax.size  = 3'd2;
                ax.burst = take_bits(1) ? burst_incr : burst_fixed;
            end else begin
                write = 1'b0;
            end
            ax.id   = 4'(take_bits(4));
            ax.prot = 3'(take_bits(3));
            if (write) begin
                run_write(ax);
            end else begin
                run_read(ax);
            end
        end
        repeat (4) @(posedge aclk);
        if (exp_apb.size() == 0 && exp_b.size() == 0 && exp_r.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("expected APB transfers or responses never arrived");
        end
    end

endmodule

// ==== dv/axi2apb_shim_checker.sv ====
`timescale 1ns/1ps

module axi2apb_shim_checker
    import axi2apb_pkg::*;
(
    input logic     aclk,
    input logic     aresetn,
    input logic     i_aw_hs,
    input logic     i_ar_hs,
    input apb_req_t i_apb_req,
    input apb_rsp_t i_apb_rsp,
    input axi_b_t   i_b,
    input logic     i_b_valid,
    input logic     i_b_ready,
    input axi_r_t   i_r,
    input logic     i_r_valid,
    input logic     i_r_ready
);

    logic accepted;

    // Set once any address request has been taken
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            accepted <= 1'b0;
        end else if (i_aw_hs || i_ar_hs) begin
            accepted <= 1'b1;
        end
    end

    penable_needs_psel: assert property (@(posedge aclk) disable iff (!aresetn)
        i_apb_req.penable |-> i_apb_req.psel)
        else $error("PENABLE high without PSEL");

    apb_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        i_apb_req.penable && !i_apb_rsp.pready |=> $stable(i_apb_req))
        else $error("APB request changed during a wait state");

    b_held: assert property (@(posedge aclk) disable iff (!aresetn)
        i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b))
        else $error("B response dropped or changed before BREADY");

    r_held: assert property (@(posedge aclk) disable iff (!aresetn)
        i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
        else $error("R beat dropped or changed before RREADY");

    no_early_psel: assert property (@(posedge aclk) disable iff (!aresetn)
        i_apb_req.psel |-> accepted)
        else $error("PSEL raised before any request was accepted");

endmodule

bind axi2apb_shim axi2apb_shim_checker u_checker (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_aw_hs   (i_aw_valid && o_aw_ready),
    .i_ar_hs   (i_ar_valid && o_ar_ready),
    .i_apb_req (o_apb),
    .i_apb_rsp (i_apb),
    .i_b       (o_b),
    .i_b_valid (o_b_valid),
    .i_b_ready (i_b_ready),
    .i_r       (o_r),
    .i_r_valid (o_r_valid),
    .i_r_ready (i_r_ready)
);

// ==== verilog/axi2apb_shim.sv ====
`timescale 1ns/1ps

module axi2apb_shim
    import axi2apb_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,

    input  axi_ax_t  i_aw,
    input  logic     i_aw_valid,
    output logic     o_aw_ready,

    input  axi_w_t   i_w,
    input  logic     i_w_valid,
    output logic     o_w_ready,

    output axi_b_t   o_b,
    output logic     o_b_valid,
    input  logic     i_b_ready,

    input  axi_ax_t  i_ar,
    input  logic     i_ar_valid,
    output logic     o_ar_ready,

    output axi_r_t   o_r,
    output logic     o_r_valid,
    input  logic     i_r_ready,

    output apb_req_t o_apb,
    input  apb_rsp_t i_apb
);

    logic              cnt_load;
    axi_ax_t           cnt_ax;
    logic              cnt_step;
    logic [ADDR_W-1:0] beat_addr;
    logic              beat_last;

    logic              cmd_req;
    apb_cmd_t          cmd;
    logic              cmd_ack;
    apb_result_t       result;

    axi2apb_ctrl_fsm u_ctrl_fsm (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_aw        (i_aw),
        .i_aw_valid  (i_aw_valid),
        .o_aw_ready  (o_aw_ready),
        .i_w         (i_w),
        .i_w_valid   (i_w_valid),
        .o_w_ready   (o_w_ready),
        .o_b         (o_b),
        .o_b_valid   (o_b_valid),
        .i_b_ready   (i_b_ready),
        .i_ar        (i_ar),
        .i_ar_valid  (i_ar_valid),
        .o_ar_ready  (o_ar_ready),
        .o_r         (o_r),
        .o_r_valid   (o_r_valid),
        .i_r_ready   (i_r_ready),
        .o_cnt_load  (cnt_load),
        .o_cnt_ax    (cnt_ax),
        .o_cnt_step  (cnt_step),
        .i_beat_addr (beat_addr),
        .i_beat_last (beat_last),
        .o_cmd_req   (cmd_req),
        .o_cmd       (cmd),
        .i_cmd_ack   (cmd_ack),
        .i_result    (result)
    );

    axi2apb_burst_counter u_burst_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_load  (cnt_load),
        .i_ax    (cnt_ax),
        .i_step  (cnt_step),
        .o_addr  (beat_addr),
        .o_last  (beat_last)
    );

    apb_master u_apb_master (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_cmd_req (cmd_req),
        .i_cmd     (cmd),
        .o_cmd_ack (cmd_ack),
        .o_result  (result),
        .o_apb     (o_apb),
        .i_apb     (i_apb)
    );

endmodule

// ==== verilog/axi2apb_ctrl_fsm.sv ====
`timescale 1ns/1ps

module axi2apb_ctrl_fsm
    import axi2apb_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,

    input  axi_ax_t           i_aw,
    input  logic              i_aw_valid,
    output logic              o_aw_ready,
    input  axi_w_t            i_w,
    input  logic              i_w_valid,
    output logic              o_w_ready,
    output axi_b_t            o_b,
    output logic              o_b_valid,
    input  logic              i_b_ready,
    input  axi_ax_t           i_ar,
    input  logic              i_ar_valid,
    output logic              o_ar_ready,
    output axi_r_t            o_r,
    output logic              o_r_valid,
    input  logic              i_r_ready,

    output logic              o_cnt_load,
    output axi_ax_t           o_cnt_ax,
    output logic              o_cnt_step,
    input  logic [ADDR_W-1:0] i_beat_addr,
    input  logic              i_beat_last,

    output logic              o_cmd_req,
    output apb_cmd_t          o_cmd,
    input  logic              i_cmd_ack,
    input  apb_result_t       i_result
);

    ctrl_state_e       state;
    ctrl_state_e       state_nxt;
    logic              is_write;
    logic              err_q;
    logic [ID_W-1:0]   id_q;
    logic [PROT_W-1:0] prot_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic              aw_hs;
    logic              ar_hs;
    logic              w_hs;
    logic              b_hs;
    logic              r_hs;

    // Write wins when both address channels wait in idle
    assign o_aw_ready = (state == st_idle) && i_aw_valid;
    assign o_ar_ready = (state == st_idle) && i_ar_valid && !i_aw_valid;
    assign o_w_ready  = (state == st_w_data);
    assign o_b_valid  = (state == st_b_resp);
    assign o_r_valid  = (state == st_r_data);
    assign o_cmd_req  = (state == st_apb_req);

    assign aw_hs = i_aw_valid && o_aw_ready;
    assign ar_hs = i_ar_valid && o_ar_ready;
    assign w_hs  = i_w_valid && o_w_ready;
    assign b_hs  = o_b_valid && i_b_ready;
    assign r_hs  = o_r_valid && i_r_ready;

    assign o_cnt_load = aw_hs || ar_hs;
    assign o_cnt_ax   = aw_hs ? i_aw : i_ar;
    // Only non-final write beats pass through release
    assign o_cnt_step = ((state == st_apb_release) && !i_cmd_ack) || (r_hs && !i_beat_last);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (aw_hs) begin
                    state_nxt = st_w_data;
                end else if (ar_hs) begin
                    state_nxt = st_apb_req;
                end
            end
            st_w_data: begin
                if (w_hs) begin
                    state_nxt = st_apb_req;
                end
            end
            st_apb_req: begin
                if (i_cmd_ack) begin
                    if (!is_write) begin
                        state_nxt = st_r_data;
                    end else if (i_beat_last) begin
                        state_nxt = st_b_resp;
                    end else begin
                        state_nxt = st_apb_release;
                    end
                end
            end
            st_apb_release: begin
                if (!i_cmd_ack) begin
                    state_nxt = st_w_data;
                end
            end
            st_b_resp: begin
                if (b_hs) begin
                    state_nxt = st_idle;
                end
            end
            st_r_data: begin
                if (r_hs) begin
                    state_nxt = i_beat_last ? st_idle : st_apb_req;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= st_idle;
            is_write <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (o_cnt_load) begin
                is_write <= aw_hs;
                err_q    <= 1'b0;
            end else if ((state == st_apb_req) && i_cmd_ack && is_write) begin
                // Any failing beat fails the whole write burst
                err_q <= err_q | i_result.slverr;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (o_cnt_load) begin
            id_q   <= o_cnt_ax.id;
            prot_q <= o_cnt_ax.prot;
        end
        if (w_hs) begin
            wdata_q <= i_w.data;
            wstrb_q <= i_w.strb;
        end
    end

    always_comb begin
        o_cmd.op    = is_write ? op_write : op_read;
        o_cmd.addr  = i_beat_addr;
        o_cmd.wdata = wdata_q;
        o_cmd.strb  = wstrb_q;
        o_cmd.prot  = prot_q;
    end

    assign o_b.id   = id_q;
    assign o_b.resp = err_q ? resp_slverr : resp_okay;

    // Master holds its result until the next transfer starts
    assign o_r.id   = id_q;
    assign o_r.data = i_result.rdata;
    assign o_r.resp = i_result.slverr ? resp_slverr : resp_okay;
    assign o_r.last = i_beat_last;

endmodule

// ==== verilog/apb_master.sv ====
`timescale 1ns/1ps

module apb_master
    import axi2apb_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        i_cmd_req,
    input  apb_cmd_t    i_cmd,
    output logic        o_cmd_ack,
    output apb_result_t o_result,
    output apb_req_t    o_apb,
    input  apb_rsp_t    i_apb
);

    logic              psel_q;
    logic              penable_q;
    logic              ack_q;
    logic [ADDR_W-1:0] paddr_q;
    logic              pwrite_q;
    logic [DATA_W-1:0] pwdata_q;
    logic [STRB_W-1:0] pstrb_q;
    logic [PROT_W-1:0] pprot_q;
    apb_result_t       result_q;
    logic              start;
    logic              done;

    // New transfer only once the previous ack has been released
    assign start = i_cmd_req && !ack_q && !psel_q;
    assign done  = psel_q && penable_q && i_apb.pready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            if (start) begin
                psel_q <= 1'b1;
            end else if (done) begin
                psel_q <= 1'b0;
            end
            // Setup lasts exactly one cycle
            if (psel_q && !penable_q) begin
                penable_q <= 1'b1;
            end else if (done) begin
                penable_q <= 1'b0;
            end
            if (done) begin
                ack_q <= 1'b1;
            end else if (!i_cmd_req) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            paddr_q  <= i_cmd.addr;
            pwrite_q <= (i_cmd.op == op_write);
            pwdata_q <= (i_cmd.op == op_write) ? i_cmd.wdata : '0;
            pstrb_q  <= (i_cmd.op == op_write) ? i_cmd.strb : '0;
            pprot_q  <= i_cmd.prot;
        end
        if (done) begin
            result_q.rdata  <= i_apb.prdata;
            result_q.slverr <= i_apb.pslverr;
        end
    end

    always_comb begin
        o_apb.psel    = psel_q;
        o_apb.penable = penable_q;
        o_apb.paddr   = paddr_q;
        o_apb.pwrite  = pwrite_q;
        o_apb.pwdata  = pwdata_q;
        o_apb.pstrb   = pstrb_q;
        o_apb.pprot   = pprot_q;
    end

    assign o_cmd_ack = ack_q;
    assign o_result  = result_q;

endmodule

// ==== verilog/axi2apb_burst_counter.sv ====
`timescale 1ns/1ps

module axi2apb_burst_counter
    import axi2apb_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              i_load,
    input  axi_ax_t           i_ax,
    input  logic              i_step,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_last
);

    logic [LEN_W-1:0]  remain_q;
    logic [ADDR_W-1:0] addr_q;
    logic [2:0]        size_q;
    axi_burst_e        burst_q;
    logic [ADDR_W-1:0] bytes;
    logic [ADDR_W-1:0] addr_nxt;

    assign bytes = ADDR_W'(1) << size_q;

    // WRAP is handled like INCR; later beats land on size boundaries
    always_comb begin
        if (burst_q == burst_fixed) begin
            addr_nxt = addr_q;
        end else begin
            addr_nxt = (addr_q & ~(bytes - ADDR_W'(1))) + bytes;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            remain_q <= '0;
        end else if (i_load) begin
            remain_q <= i_ax.len;
        end else if (i_step && (remain_q != '0)) begin
            remain_q <= remain_q - LEN_W'(1);
        end
    end

    always_ff @(posedge aclk) begin
        if (i_load) begin
            addr_q  <= i_ax.addr;
            size_q  <= i_ax.size;
            burst_q <= i_ax.burst;
        end else if (i_step) begin
            addr_q <= addr_nxt;
        end
    end

    assign o_addr = addr_q;
    assign o_last = (remain_q == '0);

endmodule

// ==== verilog/axi2apb_pkg.sv ====
package axi2apb_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int PROT_W = 3;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } apb_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_w_data,
        st_apb_req,
        st_apb_release,
        st_b_resp,
        st_r_data
    } ctrl_state_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        axi_burst_e        burst;
        logic [PROT_W-1:0] prot;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic [ADDR_W-1:0] paddr;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
        logic [PROT_W-1:0] pprot;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // One APB transfer as issued by the control FSM
    typedef struct packed {
        apb_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [PROT_W-1:0] prot;
    } apb_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              slverr;
    } apb_result_t;

endpackage
